// ==== bench/axi_mem_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_checker
    import axi_mem_pkg::*;
(
    input wire    aximm,
    input wire    arst_n,
    input axi_b_t b,
    input wire    b_valid,
    input wire    b_ready,
    input axi_r_t r,
    input wire    r_valid,
    input wire    r_ready
);

    // expected responses, in issue order per channel
    axi_b_t exp_b[$];
    axi_r_t exp_r[$];
    int     mismatches = 0;
    int     unexpected = 0;

    task automatic expect_b(input axi_b_t e);
        exp_b.push_back(e);
    endtask

    task automatic expect_r(input axi_r_t e);
        exp_r.push_back(e);
    endtask

    function automatic int pending();
        return exp_b.size() + exp_r.size();
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] want,
                           input logic [DATA_W-1:0] got);
        if (want !== got) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, want, got);
            mismatches++;
        end
    endtask

    // --------------------------------------------------
    // B channel, one check per handshake
    // --------------------------------------------------
    always @(posedge aximm) begin : watch_b
        axi_b_t e;
        if (arst_n && b_valid && b_ready) begin
            if (exp_b.size() == 0) begin
                $display("ERROR at %0t: a B response arrived with no write outstanding", $time);
                unexpected++;
            end else begin
                e = exp_b.pop_front();
                compare("b.id", DATA_W'(e.id), DATA_W'(b.id));
                compare("b.resp", DATA_W'(e.resp), DATA_W'(b.resp));
            end
        end
    end

    // --------------------------------------------------
    // R channel, every beat
    // --------------------------------------------------
    always @(posedge aximm) begin : watch_r
        axi_r_t e;
        if (arst_n && r_valid && r_ready) begin
            if (exp_r.size() == 0) begin
                $display("ERROR at %0t: an R beat arrived with no read outstanding", $time);
                unexpected++;
            end else begin
                e = exp_r.pop_front();
                compare("r.id", DATA_W'(e.id), DATA_W'(r.id));
                compare("r.data", e.data, r.data);
                compare("r.resp", DATA_W'(e.resp), DATA_W'(r.resp));
                compare("r.last", DATA_W'(e.last), DATA_W'(r.last));
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/axi_mem_patterns.txt ====
# W id addr len burst strb resp data...   burst 0 fixed 1 incr 2 wrap, resp 0 okay 2 slverr
# R id addr len burst then data resp per beat, S runs the group above it, all fields hex
W 1 100 3 1 f 0 11111111 22222222 33333333 44444444
S
R 2 100 3 1 11111111 0 22222222 0 33333333 0 44444444 0
S
W 3 104 0 1 5 0 aabbccdd
W 4 108 1 1 a 0 55667788 99aabbcc
S
W 5 208 3 2 f 0 a0000000 a1111111 a2222222 a3333333
R 6 100 3 1 11111111 0 22bb22dd 0 55337733 0 9944bb44 0
S
R 7 200 3 1 a2222222 0 a3333333 0 a0000000 0 a1111111 0
R 8 204 3 2 a3333333 0 a0000000 0 a1111111 0 a2222222 0
W 9 300 3 0 f 0 c0c0c0c0 c1c1c1c1 c2c2c2c2 c3c3c3c3
S
R b 300 2 0 c3c3c3c3 0 c3c3c3c3 0 c3c3c3c3 0
W c 3f8 3 1 f 2 d0d0d0d0 d1d1d1d1 d2d2d2d2 d3d3d3d3
S
R d 3f8 3 1 d0d0d0d0 0 d1d1d1d1 0 0 2 0 2
W e 40 5 1 f 0 e0e0e0e0 e1e1e1e1 e2e2e2e2 e3e3e3e3 e4e4e4e4 e5e5e5e5
S
W 0 80 1 1 f 0 12345678 9abcdef0
R f 40 5 1 e0e0e0e0 0 e1e1e1e1 0 e2e2e2e2 0 e3e3e3e3 0 e4e4e4e4 0 e5e5e5e5 0
R 1 80 1 1 12345678 0 9abcdef0 0

// ==== bench/tb_axi_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem
    import axi_mem_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic    aximm = 1'b0;
    logic    arst_n;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    // parsed transactions waiting for the next group run
    axi_aw_t wr_reqs[$];
    axi_w_t  wr_beats[$];
    axi_ar_t rd_reqs[$];

    string       line;
    int          pos;
    int          failures = 0;

    always #10 aximm = ~aximm;

    axi_mem_top #(.MEM_DEPTH(256)) u_dut (.*);

    axi_mem_checker u_chk (.*);

    // --------------------------------------------------
    // pattern line parsing
    // --------------------------------------------------
    // next whitespace separated hex field of the current line
    task automatic next_hex(output logic [31:0] v);
        int i;
        while (pos < line.len() && line.getc(pos) <= 8'd32) pos++;
        i = pos;
        while (pos < line.len() && line.getc(pos) > 8'd32) pos++;
        v = line.substr(i, pos - 1).atohex();
    endtask

    // W id addr len burst strb resp, then one data word per beat
    task automatic parse_write();
        axi_aw_t           req;
        axi_w_t            beat;
        axi_b_t            want;
        logic [31:0]       v;
        logic [STRB_W-1:0] strb;
        next_hex(v);
        req.id = v[ID_W-1:0];
        next_hex(v);
        req.addr = v;
        next_hex(v);
        req.len = v[7:0];
        next_hex(v);
        req.burst = axi_burst_t'(v[1:0]);
        next_hex(v);
        strb = v[STRB_W-1:0];
        next_hex(v);
        want.resp = axi_resp_t'(v[1:0]);
        want.id = req.id;
        wr_reqs.push_back(req);
        for (int k = 0; k <= int'(req.len); k++) begin
            next_hex(v);
            beat.data = v;
            beat.strb = strb;
            // last goes on beat len
            beat.last = (k == int'(req.len));
            wr_beats.push_back(beat);
        end
        u_chk.expect_b(want);
    endtask

    // R id addr len burst, then a data and resp pair per beat
    task automatic parse_read();
        axi_ar_t     req;
        axi_r_t      want;
        logic [31:0] v;
        next_hex(v);
        req.id = v[ID_W-1:0];
        next_hex(v);
        req.addr = v;
        next_hex(v);
        req.len = v[7:0];
        next_hex(v);
        req.burst = axi_burst_t'(v[1:0]);
        rd_reqs.push_back(req);
        for (int k = 0; k <= int'(req.len); k++) begin
            next_hex(v);
            want.data = v;
            next_hex(v);
            want.resp = axi_resp_t'(v[1:0]);
            want.id = req.id;
            want.last = (k == int'(req.len));
            u_chk.expect_r(want);
        end
    endtask

    // --------------------------------------------------
    // bus masters, all driving on the falling edge
    // --------------------------------------------------
    function automatic logic random_ready();
        // ready about three cycles in four
        return ($urandom % 4) != 0;
    endfunction

    // a handshake output that must be low at this point
    task automatic check_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("MISMATCH at %0t: %s expected 0 actual %b", $time, name, v);
            failures++;
        end
    endtask

    // ready is state driven in the DUT, so it is stable at the falling edge
    task automatic wait_ready(input int ch, input string what, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            case (ch)
                0: ok = aw_ready;
                1: ok = w_ready;
                default: ok = ar_ready;
            endcase
            if (!ok) begin
                @(negedge aximm);
                n++;
            end
        end
        if (!ok) begin
            $display("ERROR at %0t: timed out waiting for %s", $time, what);
            failures++;
        end
    endtask

    // random ready on B or R until one response is taken
    task automatic accept_response(input bit is_read, output bit ok);
        int   n;
        logic rdy;
        n = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            rdy = random_ready();
            if (is_read) r_ready = rdy;
            else b_ready = rdy;
            ok = rdy && (is_read ? r_valid : b_valid);
            @(negedge aximm);
            n++;
        end
        // only this channel's ready, the other master runs alongside
        if (is_read) r_ready = 1'b0;
        else b_ready = 1'b0;
        if (!ok) begin
            $display("ERROR at %0t: timed out waiting for a %s response", $time,
                     is_read ? "read" : "write");
            failures++;
        end
    endtask

    task automatic run_writes();
        axi_aw_t req;
        bit      ok;
        while (wr_reqs.size() > 0 && failures == 0) begin
            req = wr_reqs.pop_front();
            aw = req;
            aw_valid = 1'b1;
            wait_ready(0, "aw_ready", ok);
            if (!ok) return;
            @(negedge aximm);
            aw_valid = 1'b0;
            // aw_ready is a single-cycle pulse
            check_low("aw_ready", aw_ready);
            for (int k = 0; k <= int'(req.len); k++) begin
                w = wr_beats.pop_front();
                w_valid = 1'b1;
                wait_ready(1, "w_ready", ok);
                if (!ok) return;
                @(negedge aximm);
            end
            w_valid = 1'b0;
            // w_ready drops after the beat with last
            check_low("w_ready", w_ready);
            accept_response(1'b0, ok);
            if (!ok) return;
        end
    endtask

    task automatic run_reads();
        axi_ar_t req;
        bit      ok;
        while (rd_reqs.size() > 0 && failures == 0) begin
            req = rd_reqs.pop_front();
            ar = req;
            ar_valid = 1'b1;
            wait_ready(2, "ar_ready", ok);
            if (!ok) return;
            @(negedge aximm);
            ar_valid = 1'b0;
            // ar_ready is a single-cycle pulse
            check_low("ar_ready", ar_ready);
            for (int k = 0; k <= int'(req.len); k++) begin
                accept_response(1'b1, ok);
                if (!ok) return;
            end
        end
    endtask

    // one idle cycle lets the store drop its last grant,
    // then writes and reads of one group are offered side by side
    task automatic run_group();
        @(negedge aximm);
        fork
            run_writes();
            run_reads();
        join
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main
        int fd;
        arst_n   = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        void'($urandom(32'h87d9));
        repeat (5) @(negedge aximm);
        // handshake outputs are all low in reset
        check_low("aw_ready", aw_ready);
        check_low("w_ready", w_ready);
        check_low("b_valid", b_valid);
        check_low("ar_ready", ar_ready);
        check_low("r_valid", r_valid);
        arst_n = 1'b1;
        fd = $fopen("bench/axi_mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the pattern file could not be opened");
            failures++;
        end else begin
            while (failures == 0 && $fgets(line, fd) != 0) begin
                pos = 1;
                case (line.getc(0))
                    "W": parse_write();
                    "R": parse_read();
                    "S": run_group();
                    default: ;
                endcase
            end
            $fclose(fd);
            // whatever follows the last sync line
            run_group();
        end
        @(negedge aximm);
        if (u_chk.pending() != 0) begin
            $display("ERROR: %0d expected responses never arrived", u_chk.pending());
            failures++;
        end
        $display("errors: %0d mismatched, %0d unexpected, %0d other",
                 u_chk.mismatches, u_chk.unexpected, failures);
        if (u_chk.mismatches == 0 && u_chk.unexpected == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/axi_burst_addr.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_burst_addr
    import axi_mem_pkg::*;
#(
    parameter type req_t = axi_aw_t
) (
    input  wire               aximm,
    input  wire               arst_n,
    input  wire               load,
    input  req_t              req,
    input  wire               step,
    output logic [ADDR_W-1:0] addr
);

    localparam int OFF_W = $clog2(BEAT_BYTES);

    logic [ADDR_W-1:0] cur_addr;
    logic [7:0]        cur_len;
    axi_burst_t        cur_burst;

    logic [ADDR_W-1:0] incr_addr;
    logic [ADDR_W-1:0] wrap_mask;
    logic [ADDR_W-1:0] wrap_addr;

    // --------------------------------------------------
    // next address candidates
    // --------------------------------------------------
    assign incr_addr = cur_addr + ADDR_W'(BEAT_BYTES);

    // window is (len+1) beats, len is 1/3/7/15 so this is a power of two
    assign wrap_mask = (ADDR_W'(cur_len) << OFF_W) | ADDR_W'(BEAT_BYTES - 1);

    // upper bits stay on the window base, low bits roll over at the top
    assign wrap_addr = (cur_addr & ~wrap_mask) | (incr_addr & wrap_mask);

    always_ff @(posedge aximm or negedge arst_n) begin
        if (!arst_n) begin
            cur_addr  <= '0;
            cur_len   <= '0;
            cur_burst <= BURST_FIXED;
        end else if (load) begin
            cur_addr  <= req.addr;
            cur_len   <= req.len;
            cur_burst <= req.burst;
        end else if (step) begin
            case (cur_burst)
                BURST_INCR: cur_addr <= incr_addr;
                BURST_WRAP: cur_addr <= wrap_addr;
                // fixed and reserved codes keep the address
                default:    cur_addr <= cur_addr;
            endcase
        end
    end

    assign addr = cur_addr;

    // wrap only works on a power-of-two window of 2 to 16 beats
    wrap_len_legal: assert property (@(posedge aximm) disable iff (!arst_n)
        (load && req.burst == BURST_WRAP) |-> (req.len inside {8'd1, 8'd3, 8'd7, 8'd15}));

endmodule

`default_nettype wire

// ==== design/axi_mem_pkg.sv ====
`default_nettype none

package axi_mem_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 4;
    // every beat is full width, no narrow transfers
    localparam int BEAT_BYTES = 4;

    // --------------------------------------------------
    // burst and response codes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    // only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // --------------------------------------------------
    // AXI channel payloads, valid/ready travel beside them
    // --------------------------------------------------
    // write request, len is beats minus one
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        axi_burst_t        burst;
    } axi_aw_t;

    // read request, same layout as aw
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        axi_burst_t        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_t       resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_t         resp;
        logic              last;
    } axi_r_t;

    // --------------------------------------------------
    // engine to store access
    // --------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic              we;
    } mem_req_t;

    // oor flags a word index past the memory depth
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              oor;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/axi_mem_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_store
    import axi_mem_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  wire      aximm,
    input  wire      arst_n,
    input  wire      wr_busy,
    input  wire      rd_busy,
    output logic     grant_wr,
    output logic     grant_rd,
    input  wire      wr_acc,
    input  mem_req_t wr_req,
    input  wire      rd_acc,
    input  mem_req_t rd_req,
    output mem_rsp_t wr_rsp,
    output mem_rsp_t rd_rsp
);

    localparam int OFF_W = $clog2(BEAT_BYTES);
    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    mem_req_t          sel_req;
    logic              sel_acc;
    logic [ADDR_W-1:0] word_idx;
    logic [IDX_W-1:0]  mem_idx;
    logic              oor;
    mem_rsp_t          rsp_q;

    // --------------------------------------------------
    // arbitration, writer wins a tie, grant held while busy
    // --------------------------------------------------
    always_ff @(posedge aximm or negedge arst_n) begin
        if (!arst_n) begin
            grant_wr <= 1'b0;
            grant_rd <= 1'b0;
        end else if (grant_wr) begin
            if (!wr_busy) grant_wr <= 1'b0;
        end else if (grant_rd) begin
            if (!rd_busy) grant_rd <= 1'b0;
        end else if (wr_busy) begin
            grant_wr <= 1'b1;
        end else if (rd_busy) begin
            grant_rd <= 1'b1;
        end
    end

    // only the granted engine reaches the array
    assign sel_req = grant_wr ? wr_req : rd_req;
    assign sel_acc = (grant_wr && wr_acc) || (grant_rd && rd_acc);

    // range check on the full word index
    assign word_idx = sel_req.addr >> OFF_W;
    assign mem_idx  = word_idx[IDX_W-1:0];
    assign oor      = (word_idx >= ADDR_W'(MEM_DEPTH));

    // --------------------------------------------------
    // byte-strobed word array
    // --------------------------------------------------
    always_ff @(posedge aximm) begin
        if (sel_acc && sel_req.we && !oor) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (sel_req.strb[i]) begin
                    mem[mem_idx][i*8 +: 8] <= sel_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // result is valid the cycle after acc, zero past the end
    always_ff @(posedge aximm) begin
        if (sel_acc) begin
            rsp_q.rdata <= oor ? '0 : mem[mem_idx];
            rsp_q.oor   <= oor;
        end
    end

    assign wr_rsp = rsp_q;
    assign rd_rsp = rsp_q;

    grant_onehot: assert property (@(posedge aximm) disable iff (!arst_n)
        !(grant_wr && grant_rd));

endmodule

`default_nettype wire

// ==== design/axi_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top
    import axi_mem_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  wire     aximm,
    input  wire     arst_n,
    // write request
    input  axi_aw_t aw,
    input  wire     aw_valid,
    output logic    aw_ready,
    // write data
    input  axi_w_t  w,
    input  wire     w_valid,
    output logic    w_ready,
    // write response
    output axi_b_t  b,
    output logic    b_valid,
    input  wire     b_ready,
    // read request
    input  axi_ar_t ar,
    input  wire     ar_valid,
    output logic    ar_ready,
    // read data
    output axi_r_t  r,
    output logic    r_valid,
    input  wire     r_ready
);

    // --------------------------------------------------
    // engine to store wiring
    // --------------------------------------------------
    logic     wr_busy;
    logic     rd_busy;
    logic     grant_wr;
    logic     grant_rd;
    logic     wr_acc;
    logic     rd_acc;
    mem_req_t wr_req;
    mem_req_t rd_req;
    mem_rsp_t wr_rsp;
    mem_rsp_t rd_rsp;

    axi_wr_engine u_wr (
        .aximm    (aximm),
        .arst_n   (arst_n),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_busy  (wr_busy),
        .grant_wr (grant_wr),
        .acc      (wr_acc),
        .mem_req  (wr_req),
        .mem_rsp  (wr_rsp)
    );

    axi_rd_engine u_rd (
        .aximm    (aximm),
        .arst_n   (arst_n),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_busy  (rd_busy),
        .grant_rd (grant_rd),
        .acc      (rd_acc),
        .mem_req  (rd_req),
        .mem_rsp  (rd_rsp)
    );

    // shared word array of MEM_DEPTH words
    axi_mem_store #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_store (
        .aximm    (aximm),
        .arst_n   (arst_n),
        .wr_busy  (wr_busy),
        .rd_busy  (rd_busy),
        .grant_wr (grant_wr),
        .grant_rd (grant_rd),
        .wr_acc   (wr_acc),
        .wr_req   (wr_req),
        .rd_acc   (rd_acc),
        .rd_req   (rd_req),
        .wr_rsp   (wr_rsp),
        .rd_rsp   (rd_rsp)
    );

endmodule

`default_nettype wire

// ==== design/axi_rd_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_rd_engine
    import axi_mem_pkg::*;
(
    input  wire      aximm,
    input  wire      arst_n,
    input  axi_ar_t  ar,
    input  wire      ar_valid,
    output logic     ar_ready,
    output axi_r_t   r,
    output logic     r_valid,
    input  wire      r_ready,
    output logic     rd_busy,
    input  wire      grant_rd,
    output logic     acc,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_ACC,
        S_FILL,
        S_OUT
    } rd_state_t;

    rd_state_t         state;
    logic [7:0]        len_q;
    logic [7:0]        beat_cnt;
    logic [ID_W-1:0]   id_q;
    logic              load;
    logic              r_done;
    logic [ADDR_W-1:0] beat_addr;

    assign ar_ready = (state == S_ADDR);
    assign r_valid  = (state == S_OUT);
    assign acc      = (state == S_ACC);
    assign rd_busy  = (state != S_IDLE) || ar_valid;

    assign load   = ar_valid && ar_ready;
    assign r_done = r_valid && r_ready;

    // --------------------------------------------------
    // beat sequencing, three cycles per beat
    // --------------------------------------------------
    always_ff @(posedge aximm or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            len_q    <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: if (ar_valid && grant_rd) state <= S_ADDR;
                S_ADDR: begin
                    len_q    <= ar.len;
                    beat_cnt <= '0;
                    state    <= S_ACC;
                end
                S_ACC:  state <= S_FILL;
                S_FILL: state <= S_OUT;
                // stalls here while r_ready is low
                S_OUT: if (r_done) begin
                    beat_cnt <= beat_cnt + 8'd1;
                    state    <= r.last ? S_IDLE : S_ACC;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aximm) begin
        if (load) begin
            id_q <= ar.id;
        end
    end

    // output register loads from the registered store result
    always_ff @(posedge aximm) begin
        if (state == S_FILL) begin
            r.id   <= id_q;
            r.data <= mem_rsp.oor ? '0 : mem_rsp.rdata;
            r.resp <= mem_rsp.oor ? RESP_SLVERR : RESP_OKAY;
            r.last <= (beat_cnt == len_q);
        end
    end

    // address moves on once the beat is handed over
    axi_burst_addr #(
        .req_t (axi_ar_t)
    ) u_addr (
        .aximm  (aximm),
        .arst_n (arst_n),
        .load   (load),
        .req    (ar),
        .step   (r_done),
        .addr   (beat_addr)
    );

    assign mem_req.addr  = beat_addr;
    assign mem_req.wdata = '0;
    assign mem_req.strb  = '0;
    assign mem_req.we    = 1'b0;

    // a stalled beat keeps its payload until the master takes it
    r_held: assert property (@(posedge aximm) disable iff (!arst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

`default_nettype wire

// ==== design/axi_wr_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_wr_engine
    import axi_mem_pkg::*;
(
    input  wire      aximm,
    input  wire      arst_n,
    input  axi_aw_t  aw,
    input  wire      aw_valid,
    output logic     aw_ready,
    input  axi_w_t   w,
    input  wire      w_valid,
    output logic     w_ready,
    output axi_b_t   b,
    output logic     b_valid,
    input  wire      b_ready,
    output logic     wr_busy,
    input  wire      grant_wr,
    output logic     acc,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } wr_state_t;

    wr_state_t       state;
    logic [ID_W-1:0] id_q;
    logic            err_q;
    logic            acc_q;
    logic            load;
    logic            beat_oor;
    logic [ADDR_W-1:0] beat_addr;

    // --------------------------------------------------
    // handshakes follow the state directly
    // --------------------------------------------------
    assign aw_ready = (state == S_ADDR);
    assign w_ready  = (state == S_DATA);
    assign b_valid  = (state == S_RESP);

    // busy as soon as a request shows up, until B is taken
    assign wr_busy = (state != S_IDLE) || aw_valid;

    assign load = aw_valid && aw_ready;
    assign acc  = w_valid && w_ready;

    // store answers one cycle after each access
    assign beat_oor = acc_q && mem_rsp.oor;

    always_ff @(posedge aximm or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            acc_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            acc_q <= acc;
            case (state)
                S_IDLE: if (aw_valid && grant_wr) state <= S_ADDR;
                S_ADDR: state <= S_DATA;
                S_DATA: if (acc && w.last) state <= S_RESP;
                S_RESP: if (b_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            // sticky over the whole burst, cleared on a new request
            if (load) begin
                err_q <= 1'b0;
            end else if (beat_oor) begin
                err_q <= 1'b1;
            end
        end
    end

    // id captured with the accepted request
    always_ff @(posedge aximm) begin
        if (load) begin
            id_q <= aw.id;
        end
    end

    axi_burst_addr #(
        .req_t (axi_aw_t)
    ) u_addr (
        .aximm  (aximm),
        .arst_n (arst_n),
        .load   (load),
        .req    (aw),
        .step   (acc),
        .addr   (beat_addr)
    );

    // --------------------------------------------------
    // store access and B payload
    // --------------------------------------------------
    assign mem_req.addr  = beat_addr;
    assign mem_req.wdata = w.data;
    assign mem_req.strb  = w.strb;
    assign mem_req.we    = 1'b1;

    // last beat's flag lands in the first B cycle, err_q covers the rest
    assign b.id   = id_q;
    assign b.resp = (err_q || beat_oor) ? RESP_SLVERR : RESP_OKAY;

    // request must not change while the master waits on aw_ready
    aw_held: assert property (@(posedge aximm) disable iff (!arst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_mem -f src.f -o tb_axi_mem
./obj_dir/tb_axi_mem > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

// ==== src.f ====
design/axi_mem_pkg.sv
design/axi_burst_addr.sv
design/axi_wr_engine.sv
design/axi_rd_engine.sv
design/axi_mem_store.sv
design/axi_mem_top.sv
bench/axi_mem_checker.sv
bench/tb_axi_mem.sv
